// ==== flist.f ====
hw/mul_pkg.sv
hw/mul_decode.sv
hw/mul_booth_r4.sv
hw/mul_csa_tree.sv
hw/mul_result.sv
hw/mul_top.sv
test/tb_mul_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mul_top
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "$BUILD_DIR" "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert \
  --top-module "$TOP" --Mdir "$BUILD_DIR" \
  -f flist.f > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" "$SIM_LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// ==== test/tb_mul_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mul_top import mul_pkg::*; ();

  localparam int CLK_HALF   = 50;
  localparam int RESET_CYC  = 2;
  localparam int IDLE0_CYC  = 3;
  localparam int NUM_CORNER = 5;
  localparam int CORNER_OPS = 4 * NUM_CORNER * NUM_CORNER;
  localparam int GAP_SLOTS  = 4 + 1 + 2 + 3 + 5; // four ops plus their idle gaps
  localparam int BURST_OPS  = 256;
  localparam int FLUSH_CYC  = 5;
  localparam int NUM_SLOTS  = IDLE0_CYC + CORNER_OPS + GAP_SLOTS + BURST_OPS;
  localparam int MAX_CYCLES = RESET_CYC + FLUSH_CYC + NUM_SLOTS + 20;

  logic            clk_i;
  logic            arst_n_i;
  logic            valid_i;
  mul_op_e         op_i;
  logic [XLEN-1:0] rs1_i;
  logic [XLEN-1:0] rs2_i;
  logic            valid_o;
  logic [XLEN-1:0] result_o;

  logic [31:0]     rng_state;
  logic [XLEN-1:0] corner [NUM_CORNER];
  logic            exp_valid [4]; // index 3 is due at this edge
  logic [XLEN-1:0] exp_res [4];
  int              issued;
  int              end_errors;
  int              chk_errors = 0;
  int              checks = 0;
  int              outputs = 0;
  int              cycles = 0;

  mul_top u_dut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state = s;
    return s;
  endfunction

  // M extension: mulhsu takes rs1 signed and rs2 unsigned
  function automatic logic [XLEN-1:0] ref_result(
    input mul_op_e         op,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
  );
    logic              a_sgn;
    logic              b_sgn;
    logic [PROD_W-1:0] a64;
    logic [PROD_W-1:0] b64;
    logic [PROD_W-1:0] p;
    a_sgn = (op != MULH_UU);
    b_sgn = (op == MUL_LO) || (op == MULH_SS);
    a64 = {{XLEN{a_sgn & a[XLEN-1]}}, a};
    b64 = {{XLEN{b_sgn & b[XLEN-1]}}, b};
    p = a64 * b64; // modulo 2^64 is exact for the signed product too
    return (op == MUL_LO) ? p[XLEN-1:0] : p[PROD_W-1:XLEN];
  endfunction

  task automatic issue_op(input mul_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    @(negedge clk_i);
    valid_i = 1'b1;
    op_i    = op;
    rs1_i   = a;
    rs2_i   = b;
    issued++;
  endtask

  // junk on the data inputs, the DUT must ignore it
  task automatic idle_slot();
    @(negedge clk_i);
    valid_i = 1'b0;
    op_i    = mul_op_e'(rng_state[1:0]);
    rs1_i   = next_rand();
    rs2_i   = next_rand();
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 4; i++) begin
        exp_valid[i] = 1'b0;
        exp_res[i]   = '0;
      end
    end else begin
      checks++;
      assert (valid_o === exp_valid[3]) else begin
        chk_errors++;
        $display("ERR valid_o expected %h actual %h at %0t", exp_valid[3], valid_o, $time);
      end
      if (exp_valid[3]) begin
        assert (result_o === exp_res[3]) else begin
          chk_errors++;
          $display("ERR result_o expected %h actual %h at %0t",
                   exp_res[3], result_o, $time);
        end
      end
      if (valid_o) outputs++;
      for (int i = 3; i > 0; i--) begin
        exp_valid[i] = exp_valid[i-1];
        exp_res[i]   = exp_res[i-1];
      end
      exp_valid[0] = valid_i; // what the DUT captures at this edge
      exp_res[0]   = ref_result(op_i, rs1_i, rs2_i);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0]     r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [1:0]      op_sel;
    int              gaps [4];
    rng_state  = 32'haf5b;
    corner[0]  = 32'h0000_0000;
    corner[1]  = 32'h0000_0001;
    corner[2]  = 32'hffff_ffff;
    corner[3]  = 32'h8000_0000;
    corner[4]  = 32'h7fff_ffff;
    gaps       = '{1, 2, 3, 5};
    op_sel     = 2'd0;
    issued     = 0;
    end_errors = 0;
    arst_n_i   = 1'b0;
    valid_i    = 1'b0;
    op_i       = MUL_LO;
    rs1_i      = '0;
    rs2_i      = '0;

    repeat (RESET_CYC) @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (IDLE0_CYC) idle_slot(); // nothing issued yet

    // every opcode over every corner pair
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < NUM_CORNER; i++) begin
        for (int j = 0; j < NUM_CORNER; j++) begin
          issue_op(mul_op_e'(op[1:0]), corner[i], corner[j]);
        end
      end
    end

    foreach (gaps[g]) begin
      r = next_rand();
      issue_op(mul_op_e'(r[1:0]), next_rand(), next_rand());
      repeat (gaps[g]) idle_slot();
    end

    // back to back, opcode changes every cycle
    for (int n = 0; n < BURST_OPS; n++) begin
      r = next_rand();
      a = next_rand();
      b = next_rand();
      if (r[7:5] == 3'd0) a = corner[int'(r[10:8]) % NUM_CORNER];
      if (r[13:11] == 3'd0) b = corner[int'(r[16:14]) % NUM_CORNER];
      op_sel = op_sel + 2'd1 + {1'b0, r[0]}; // step of one or two
      issue_op(mul_op_e'(op_sel), a, b);
    end

    repeat (FLUSH_CYC) idle_slot();

    assert (outputs == issued) else begin
      end_errors++;
      $display("valid_o was high %0d times for %0d issued operations", outputs, issued);
    end

    $display("errors %0d (cycle checks %0d, results %0d)",
             chk_errors + end_errors, checks, outputs);
    if (chk_errors + end_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/mul_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_top import mul_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  mul_op_e         op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o
);

  mul_req_t  dec_req;  // stage 1
  pp_array_t booth_pp; // combinational rows
  csa_pair_t csa_pair; // stage 3

  mul_decode u_decode (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .req_o    (dec_req)
  );

  mul_booth_r4 u_booth (
    .req_i (dec_req),
    .pp_o  (booth_pp)
  );

  // two register stages inside
  mul_csa_tree u_csa_tree (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (dec_req),
    .pp_i     (booth_pp),
    .pair_o   (csa_pair)
  );

  mul_result u_result (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .pair_i   (csa_pair),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

// ==== hw/mul_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_result import mul_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  csa_pair_t       pair_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o
);

  logic [PROD_W-1:0] prod;
  logic [XLEN-1:0]   half;

  // product modulo 2^64, sign handled by the Booth rows
  assign prod = pair_i.sum + pair_i.carry;

  assign half = pair_i.ctrl.hi_sel ? prod[PROD_W-1:XLEN] : prod[XLEN-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o  <= pair_i.valid;
      result_o <= half; // shifts even when idle
    end
  end

endmodule

`default_nettype wire

// ==== hw/mul_csa_tree.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_csa_tree import mul_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  mul_req_t  req_i,
  input  pp_array_t pp_i,
  output csa_pair_t pair_o
);

  typedef logic [PROD_W-1:0] row_t;

  row_t      l1 [12];
  row_t      l2 [8];
  row_t      l3 [6];
  row_t      s1_q [6]; // stage 1 rows
  logic      s1_valid_q;
  mul_ctrl_t s1_ctrl_q;
  row_t      l4 [4];
  row_t      l5 [3];
  row_t      sum_d;
  row_t      carry_d;
  logic      valid_q;
  mul_ctrl_t ctrl_q;
  row_t      sum_q;
  row_t      carry_q;

  function automatic row_t fa_sum(input row_t a, input row_t b, input row_t c);
    return a ^ b ^ c;
  endfunction

  // carry moves up one column, top bit falls off
  function automatic row_t fa_carry(input row_t a, input row_t b, input row_t c);
    return ((a & b) | (a & c) | (b & c)) << 1;
  endfunction

  // 17 -> 12
  for (genvar g = 0; g < 5; g++) begin : gen_l1
    assign l1[2*g]   = fa_sum(pp_i[3*g], pp_i[3*g+1], pp_i[3*g+2]);
    assign l1[2*g+1] = fa_carry(pp_i[3*g], pp_i[3*g+1], pp_i[3*g+2]);
  end
  assign l1[10] = pp_i[15];
  assign l1[11] = pp_i[16];

  // 12 -> 8
  for (genvar g = 0; g < 4; g++) begin : gen_l2
    assign l2[2*g]   = fa_sum(l1[3*g], l1[3*g+1], l1[3*g+2]);
    assign l2[2*g+1] = fa_carry(l1[3*g], l1[3*g+1], l1[3*g+2]);
  end

  // 8 -> 6
  for (genvar g = 0; g < 2; g++) begin : gen_l3
    assign l3[2*g]   = fa_sum(l2[3*g], l2[3*g+1], l2[3*g+2]);
    assign l3[2*g+1] = fa_carry(l2[3*g], l2[3*g+1], l2[3*g+2]);
  end
  assign l3[4] = l2[6];
  assign l3[5] = l2[7];

  // 6 -> 4 after the register
  for (genvar g = 0; g < 2; g++) begin : gen_l4
    assign l4[2*g]   = fa_sum(s1_q[3*g], s1_q[3*g+1], s1_q[3*g+2]);
    assign l4[2*g+1] = fa_carry(s1_q[3*g], s1_q[3*g+1], s1_q[3*g+2]);
  end

  assign l5[0] = fa_sum(l4[0], l4[1], l4[2]); // 4 -> 3
  assign l5[1] = fa_carry(l4[0], l4[1], l4[2]);
  assign l5[2] = l4[3];

  assign sum_d   = fa_sum(l5[0], l5[1], l5[2]);
  assign carry_d = fa_carry(l5[0], l5[1], l5[2]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
      s1_ctrl_q  <= '0;
      valid_q    <= 1'b0;
      ctrl_q     <= '0;
    end else begin
      s1_valid_q <= req_i.valid;
      s1_ctrl_q  <= req_i.ctrl;
      valid_q    <= s1_valid_q;
      ctrl_q     <= s1_ctrl_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_q    <= l3;
    sum_q   <= sum_d;
    carry_q <= carry_d;
  end

  assign pair_o = '{valid: valid_q, ctrl: ctrl_q, sum: sum_q, carry: carry_q};

endmodule

`default_nettype wire

// ==== hw/mul_booth_r4.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_booth_r4 import mul_pkg::*; (
  input  mul_req_t  req_i,
  output pp_array_t pp_o
);

  localparam int EXT_W = XLEN + 2; // room for 2x and an unsigned top bit

  logic [EXT_W-1:0] x;
  logic [EXT_W-1:0] x_dbl;
  logic [EXT_W-1:0] x_neg;
  logic [EXT_W-1:0] x_neg_dbl;
  logic [EXT_W-1:0] y;
  logic [EXT_W:0]   scan;

  // radix-4 digit from one overlapping triplet
  function automatic logic [EXT_W-1:0] booth_sel(
    input logic [2:0]       trip,
    input logic [EXT_W-1:0] p1,
    input logic [EXT_W-1:0] p2,
    input logic [EXT_W-1:0] n1,
    input logic [EXT_W-1:0] n2
  );
    logic [EXT_W-1:0] row;
    case (trip)
      3'b001, 3'b010: row = p1; // +x
      3'b011:         row = p2; // +2x
      3'b100:         row = n2; // -2x
      3'b101, 3'b110: row = n1; // -x
      default:        row = '0;
    endcase
    return row;
  endfunction

  assign x = {{2{req_i.ctrl.rs1_signed & req_i.rs1[XLEN-1]}}, req_i.rs1};
  assign y = {{2{req_i.ctrl.rs2_signed & req_i.rs2[XLEN-1]}}, req_i.rs2};

  assign x_dbl     = {x[EXT_W-2:0], 1'b0};
  assign x_neg     = -x;
  assign x_neg_dbl = {x_neg[EXT_W-2:0], 1'b0};

  // idle slots give all zero rows
  assign scan = req_i.valid ? {y, 1'b0} : '0;

  for (genvar i = 0; i < PP_NUM; i++) begin : gen_pp
    logic [EXT_W-1:0]  row;
    logic [PROD_W-1:0] row_ext;

    assign row     = booth_sel(scan[2*i+2 -: 3], x, x_dbl, x_neg, x_neg_dbl);
    assign row_ext = {{(PROD_W-EXT_W){row[EXT_W-1]}}, row};
    assign pp_o[i] = row_ext << (2 * i); // row 16 keeps only its low half
  end

endmodule

`default_nettype wire

// ==== hw/mul_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_decode import mul_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  mul_op_e         op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  output mul_req_t        req_o
);

  mul_ctrl_t       ctrl_d;
  logic            valid_q;
  mul_ctrl_t       ctrl_q;
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;

  always_comb begin
    ctrl_d = '0;
    case (op_i)
      MUL_LO: begin // low half does not care
        ctrl_d.rs1_signed = 1'b1;
        ctrl_d.rs2_signed = 1'b1;
      end
      MULH_SS: begin
        ctrl_d.rs1_signed = 1'b1;
        ctrl_d.rs2_signed = 1'b1;
      end
      MULH_SU: ctrl_d.rs1_signed = 1'b1;
      default: ; // mulhu, both zero-extended
    endcase
    ctrl_d.hi_sel = (op_i != MUL_LO);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      valid_q <= valid_i;
      ctrl_q  <= ctrl_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rs1_q <= rs1_i;
    rs2_q <= rs2_i;
  end

  assign req_o = '{valid: valid_q, ctrl: ctrl_q, rs1: rs1_q, rs2: rs2_q};

endmodule

`default_nettype wire

// ==== hw/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

  localparam int XLEN   = 32;
  localparam int PROD_W = 2 * XLEN;
  localparam int PP_NUM = XLEN / 2 + 1; // one extra row covers unsigned operands

  // funct3[1:0] of the M extension
  typedef enum logic [1:0] {
    MUL_LO  = 2'b00, // mul
    MULH_SS = 2'b01, // mulh
    MULH_SU = 2'b10, // mulhsu
    MULH_UU = 2'b11  // mulhu
  } mul_op_e;

  typedef struct packed {
    logic rs1_signed;
    logic rs2_signed;
    logic hi_sel;
  } mul_ctrl_t;

  typedef struct packed {
    logic            valid;
    mul_ctrl_t       ctrl;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } mul_req_t;

  typedef logic [PP_NUM-1:0][PROD_W-1:0] pp_array_t;

  typedef struct packed {
    logic              valid;
    mul_ctrl_t         ctrl;
    logic [PROD_W-1:0] sum;
    logic [PROD_W-1:0] carry; // already aligned, add as is
  } csa_pair_t;

endpackage

`default_nettype wire
